// ==== vlog.f ====
+incdir+common
common/pcore_pkg.sv
rtl/lsu_stage.sv
rtl/mul_unit.sv
rtl/csr_file.sv
rtl/writeback.sv
rtl/reg_file.sv
rtl/fwd_unit.sv
rtl/pcore_backend.sv
verif/backend_tb.sv

// ==== verif/backend_tb.sv ====
`default_nettype none

`include "pcore_consts.svh"

module backend_tb import pcore_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 10;
    localparam int N_BASIC    = 40;
    localparam int N_MEM      = 60;
    localparam int N_MUL      = 60;
    localparam int N_CSR      = 30;
    // A CSR op may be followed by a read of the same CSR
    localparam int NUM_INSTR  = N_BASIC + N_MEM + N_MUL + 2 * N_CSR;
    // Each instruction may be preceded by one bubble
    localparam int TIMEOUT_NS = (2 * NUM_INSTR + 100) * CLK_PERIOD;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    typedef struct packed {
        reg_addr_t              rd;
        rd_wrb_sel_e            sel;
        word_t                  alu;
        word_t                  pc_next;
        mem_op_e                mem_op;
        word_t                  mem_addr;
        word_t                  store_data;
        mul_op_e                mul_op;
        word_t                  mul_a;
        word_t                  mul_b;
        csr_op_e                csr_op;
        logic [`CSR_ADDR_W-1:0] csr_addr;
        word_t                  csr_wdata;
    } instr_t;

    typedef struct packed {
        reg_addr_t addr;
        word_t     data;
        logic      wr_req;
    } result_t;

    typedef struct packed {
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        word_t     rs1_data;
        word_t     rs2_data;
    } reads_t;

    logic                   clk = 1'b0;
    logic                   reset_i;
    logic                   ex_valid_i;
    reg_addr_t              ex_rd_addr_i;
    rd_wrb_sel_e            ex_rd_wrb_sel_i;
    word_t                  ex_alu_result_i;
    word_t                  ex_pc_next_i;
    mem_op_e                ex_mem_op_i;
    word_t                  ex_mem_addr_i;
    word_t                  ex_store_data_i;
    mul_op_e                ex_mul_op_i;
    word_t                  ex_mul_a_i;
    word_t                  ex_mul_b_i;
    csr_op_e                ex_csr_op_i;
    logic [`CSR_ADDR_W-1:0] ex_csr_addr_i;
    word_t                  ex_csr_wdata_i;
    reg_addr_t              id_rs1_addr_i;
    reg_addr_t              id_rs2_addr_i;
    word_t                  id_rs1_data_o;
    word_t                  id_rs2_data_o;
    reg_addr_t              wrb_rd_addr_o;
    word_t                  wrb_rd_data_o;
    logic                   wrb_rd_wr_req_o;

    // Architectural model state
    word_t     model_regs [2**`REG_ADDR_W];
    word_t     model_dmem [`DMEM_WORDS];
    word_t     model_mscratch;
    word_t     model_mtvec;
    reg_addr_t last_rd;

    result_t result_q [$];
    reads_t  read_q [$];

    pcore_backend dut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_word(string name, word_t exp, word_t act);
        if (act !== exp) begin
            $display("Fail at %0d ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
            abort_run("Data word mismatch");
        end
    endtask

    task automatic check_addr(string name, reg_addr_t exp, reg_addr_t act);
        if (act !== exp) begin
            $display("Fail at %0d ns: %s expected x%0d, got x%0d", $time, name, exp, act);
            abort_run("Register address mismatch");
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Fail at %0d ns: %s expected %b, got %b", $time, name, exp, act);
            abort_run("Write request mismatch");
        end
    endtask

    function automatic word_t csr_read_model(logic [`CSR_ADDR_W-1:0] addr);
        if (addr == `CSR_MSCRATCH) begin
            return model_mscratch;
        end else if (addr == `CSR_MTVEC) begin
            return model_mtvec;
        end
        return '0;
    endfunction

    // Full 64-bit product of the operands taken as signed or unsigned
    function automatic word_t mul_ref(mul_op_e op, word_t a, word_t b);
        logic [2*`XLEN-1:0] a64;
        logic [2*`XLEN-1:0] b64;
        logic [2*`XLEN-1:0] prod;
        a64 = (op == MUL_HSS || op == MUL_HSU) ? {{`XLEN{a[`XLEN-1]}}, a} : {{`XLEN{1'b0}}, a};
        b64 = (op == MUL_HSS) ? {{`XLEN{b[`XLEN-1]}}, b} : {{`XLEN{1'b0}}, b};
        prod = a64 * b64;
        return (op == MUL_LO) ? prod[`XLEN-1:0] : prod[2*`XLEN-1:`XLEN];
    endfunction

    // Expected writeback of one instruction, then its effect on the model
    function automatic result_t ref_result(instr_t ins);
        result_t res;
        word_t   csr_old;
        word_t   csr_new;
        csr_old    = csr_read_model(ins.csr_addr);
        res.addr   = ins.rd;
        res.wr_req = (ins.sel != RD_WRB_NONE) && (ins.rd != '0);
        case (ins.sel)
            RD_WRB_ALU    : res.data = ins.alu;
            RD_WRB_M_ALU  : res.data = mul_ref(ins.mul_op, ins.mul_a, ins.mul_b);
            RD_WRB_INC_PC : res.data = ins.pc_next;
            RD_WRB_DMEM   : res.data = model_dmem[ins.mem_addr[`DMEM_ADDR_W-1:0]];
            RD_WRB_CSR    : res.data = csr_old;
            default       : res.data = '0;
        endcase
        if (ins.mem_op == MEM_STORE) begin
            model_dmem[ins.mem_addr[`DMEM_ADDR_W-1:0]] = ins.store_data;
        end
        if (ins.csr_op != CSR_NONE) begin
            case (ins.csr_op)
                CSR_RW  : csr_new = ins.csr_wdata;
                CSR_RS  : csr_new = csr_old | ins.csr_wdata;
                default : csr_new = csr_old & ~ins.csr_wdata;
            endcase
            if (ins.csr_addr == `CSR_MSCRATCH) begin
                model_mscratch = csr_new;
            end else if (ins.csr_addr == `CSR_MTVEC) begin
                model_mtvec = csr_new;
            end
        end
        if (res.wr_req) begin
            model_regs[ins.rd] = res.data;
        end
        return res;
    endfunction

    // rs1 often targets the instruction now entering writeback
    task automatic drive_reads();
        reads_t exp;
        exp.rs1_addr = ($urandom_range(0, 1) == 0) ? last_rd : reg_addr_t'($urandom_range(0, 31));
        exp.rs2_addr = reg_addr_t'($urandom_range(0, 31));
        exp.rs1_data = model_regs[exp.rs1_addr];
        exp.rs2_data = model_regs[exp.rs2_addr];
        id_rs1_addr_i <= exp.rs1_addr;
        id_rs2_addr_i <= exp.rs2_addr;
        read_q.push_back(exp);
    endtask

    task automatic issue(instr_t ins, bit allow_gap);
        if (allow_gap && $urandom_range(0, 3) == 0) begin
            @(posedge clk);
            ex_valid_i <= 1'b0;
            // New store and CSR data in a bubble must be ignored by the DUT
            ex_store_data_i <= $urandom();
            ex_csr_wdata_i  <= $urandom();
            drive_reads();
        end
        @(posedge clk);
        drive_reads();
        ex_valid_i      <= 1'b1;
        ex_rd_addr_i    <= ins.rd;
        ex_rd_wrb_sel_i <= ins.sel;
        ex_alu_result_i <= ins.alu;
        ex_pc_next_i    <= ins.pc_next;
        ex_mem_op_i     <= ins.mem_op;
        ex_mem_addr_i   <= ins.mem_addr;
        ex_store_data_i <= ins.store_data;
        ex_mul_op_i     <= ins.mul_op;
        ex_mul_a_i      <= ins.mul_a;
        ex_mul_b_i      <= ins.mul_b;
        ex_csr_op_i     <= ins.csr_op;
        ex_csr_addr_i   <= ins.csr_addr;
        ex_csr_wdata_i  <= ins.csr_wdata;
        result_q.push_back(ref_result(ins));
        last_rd = ins.rd;
    endtask

    task automatic run_basic_test();
        instr_t ins;
        for (int i = 0; i < N_BASIC; i++) begin
            ins = '0;
            ins.rd = ($urandom_range(0, 7) == 0) ? '0 : reg_addr_t'($urandom_range(1, 31));
            case ($urandom_range(0, 4))
                0       : ins.sel = RD_WRB_NONE;
                1, 2    : ins.sel = RD_WRB_INC_PC;
                default : ins.sel = RD_WRB_ALU;
            endcase
            ins.alu     = $urandom();
            ins.pc_next = $urandom() & 32'hffff_fffc;
            issue(ins, 1'b1);
        end
    endtask

    task automatic run_mem_test();
        instr_t      ins;
        int unsigned stored [$];
        int unsigned addr;
        for (int i = 0; i < N_MEM; i++) begin
            ins = '0;
            ins.rd = reg_addr_t'($urandom_range(1, 31));
            if (stored.size() == 0 || $urandom_range(0, 1) == 0) begin
                // Mostly a small window so that addresses repeat
                addr = ($urandom_range(0, 3) == 0) ? $urandom_range(0, `DMEM_WORDS - 1)
                                                   : $urandom_range(0, 7);
                ins.mem_op     = MEM_STORE;
                ins.store_data = $urandom();
                stored.push_back(addr);
            end else begin
                addr = ($urandom_range(0, 1) == 0) ? stored[$]
                                                   : stored[$urandom_range(0, stored.size() - 1)];
                ins.mem_op = MEM_LOAD;
                ins.sel    = RD_WRB_DMEM;
            end
            ins.mem_addr = word_t'(addr);
            issue(ins, 1'b1);
        end
    endtask

    function automatic word_t pick_operand();
        case ($urandom_range(0, 5))
            0       : return 32'h0000_0000;
            1       : return 32'hffff_ffff;
            2       : return 32'h8000_0000;
            3       : return 32'h7fff_ffff;
            default : return $urandom();
        endcase
    endfunction

    task automatic run_mul_test();
        instr_t ins;
        for (int i = 0; i < N_MUL; i++) begin
            ins        = '0;
            ins.rd     = reg_addr_t'($urandom_range(1, 31));
            ins.sel    = RD_WRB_M_ALU;
            ins.mul_op = mul_op_e'($urandom_range(0, 3));
            ins.mul_a  = pick_operand();
            ins.mul_b  = pick_operand();
            issue(ins, 1'b0);
        end
    endtask

    task automatic run_csr_test();
        instr_t ins;
        for (int i = 0; i < N_CSR; i++) begin
            ins     = '0;
            ins.rd  = reg_addr_t'($urandom_range(1, 31));
            ins.sel = RD_WRB_CSR;
            case ($urandom_range(0, 4))
                0, 1    : ins.csr_addr = `CSR_MSCRATCH;
                2, 3    : ins.csr_addr = `CSR_MTVEC;
                default : ins.csr_addr = 12'h300;
            endcase
            ins.csr_op    = csr_op_e'($urandom_range(1, 3));
            ins.csr_wdata = $urandom();
            issue(ins, 1'b1);
            // Read back right away to see the new value
            if ($urandom_range(0, 1) == 0) begin
                ins.csr_op = CSR_NONE;
                ins.rd     = reg_addr_t'($urandom_range(1, 31));
                issue(ins, 1'b0);
            end
        end
    endtask

    initial begin : main_proc
        int unsigned seed_val;
        reset_i         = 1'b1;
        ex_valid_i      = 1'b0;
        ex_rd_addr_i    = '0;
        ex_rd_wrb_sel_i = RD_WRB_NONE;
        ex_alu_result_i = '0;
        ex_pc_next_i    = '0;
        ex_mem_op_i     = MEM_NONE;
        ex_mem_addr_i   = '0;
        ex_store_data_i = '0;
        ex_mul_op_i     = MUL_LO;
        ex_mul_a_i      = '0;
        ex_mul_b_i      = '0;
        ex_csr_op_i     = CSR_NONE;
        ex_csr_addr_i   = '0;
        ex_csr_wdata_i  = '0;
        id_rs1_addr_i   = '0;
        id_rs2_addr_i   = '0;
        for (int r = 0; r < 2**`REG_ADDR_W; r++) begin
            model_regs[r] = '0;
        end
        model_mscratch = '0;
        model_mtvec    = '0;
        last_rd        = '0;
        seed_val       = $urandom(49);
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        run_basic_test();
        run_mem_test();
        run_mul_test();
        run_csr_test();
        @(posedge clk);
        ex_valid_i <= 1'b0;
        drive_reads();
        @(posedge clk);
        if (result_q.size() == 0 && read_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            abort_run("Expected results were left unchecked at the end of the run");
        end
    end

    // Outputs are compared at the falling edge, away from the driving edge
    initial begin : compare_proc
        result_t exp_res;
        reads_t  exp_rd;
        logic    issued;
        forever begin
            @(posedge clk);
            issued = ex_valid_i && !reset_i;
            @(negedge clk);
            if (issued) begin
                if (result_q.size() == 0) begin
                    abort_run("An instruction reached writeback with no expected result");
                end
                exp_res = result_q.pop_front();
                check_addr("wrb_rd_addr_o", exp_res.addr, wrb_rd_addr_o);
                check_bit("wrb_rd_wr_req_o", exp_res.wr_req, wrb_rd_wr_req_o);
                check_word("wrb_rd_data_o", exp_res.data, wrb_rd_data_o);
            end else begin
                check_bit("wrb_rd_wr_req_o", 1'b0, wrb_rd_wr_req_o);
            end
            if (read_q.size() > 0) begin
                exp_rd = read_q.pop_front();
                check_word($sformatf("id_rs1_data_o (x%0d)", exp_rd.rs1_addr),
                           exp_rd.rs1_data, id_rs1_data_o);
                check_word($sformatf("id_rs2_data_o (x%0d)", exp_rd.rs2_addr),
                           exp_rd.rs2_data, id_rs2_data_o);
            end
        end
    end

    initial begin : watchdog_proc
        #(TIMEOUT_NS);
        abort_run("Watchdog timeout, the tests did not complete in time");
    end

endmodule : backend_tb

`default_nettype wire

// ==== rtl/pcore_backend.sv ====
`default_nettype none

`include "pcore_consts.svh"

module pcore_backend import pcore_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,

    // Issue from execute
    input  logic                   ex_valid_i,
    input  logic [`REG_ADDR_W-1:0] ex_rd_addr_i,
    input  rd_wrb_sel_e            ex_rd_wrb_sel_i,
    input  logic [`XLEN-1:0]       ex_alu_result_i,
    input  logic [`XLEN-1:0]       ex_pc_next_i,
    input  mem_op_e                ex_mem_op_i,
    input  logic [`XLEN-1:0]       ex_mem_addr_i,
    input  logic [`XLEN-1:0]       ex_store_data_i,
    input  mul_op_e                ex_mul_op_i,
    input  logic [`XLEN-1:0]       ex_mul_a_i,
    input  logic [`XLEN-1:0]       ex_mul_b_i,
    input  csr_op_e                ex_csr_op_i,
    input  logic [`CSR_ADDR_W-1:0] ex_csr_addr_i,
    input  logic [`XLEN-1:0]       ex_csr_wdata_i,

    // Decode operand reads
    input  logic [`REG_ADDR_W-1:0] id_rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] id_rs2_addr_i,
    output logic [`XLEN-1:0]       id_rs1_data_o,
    output logic [`XLEN-1:0]       id_rs2_data_o,

    // Writeback view
    output logic [`REG_ADDR_W-1:0] wrb_rd_addr_o,
    output logic [`XLEN-1:0]       wrb_rd_data_o,
    output logic                   wrb_rd_wr_req_o
);

    logic [`REG_ADDR_W-1:0] stg_rd_addr;
    rd_wrb_sel_e            stg_rd_wrb_sel;
    logic                   stg_rd_wr_req;
    logic [`XLEN-1:0]       stg_alu_result;
    logic [`XLEN-1:0]       stg_pc_next;
    logic [`XLEN-1:0]       stg_r_data;
    logic [`XLEN-1:0]       stg_alu_m_result;
    logic [`XLEN-1:0]       stg_csr_rdata;
    logic [`XLEN-1:0]       rf_rs1_data;
    logic [`XLEN-1:0]       rf_rs2_data;

    lsu_stage u_lsu_stage (
        .clk          (clk),
        .reset_i      (reset_i),
        .valid_i      (ex_valid_i),
        .rd_addr_i    (ex_rd_addr_i),
        .rd_wrb_sel_i (ex_rd_wrb_sel_i),
        .alu_result_i (ex_alu_result_i),
        .pc_next_i    (ex_pc_next_i),
        .mem_op_i     (ex_mem_op_i),
        .mem_addr_i   (ex_mem_addr_i),
        .store_data_i (ex_store_data_i),
        .rd_addr_o    (stg_rd_addr),
        .rd_wrb_sel_o (stg_rd_wrb_sel),
        .rd_wr_req_o  (stg_rd_wr_req),
        .alu_result_o (stg_alu_result),
        .pc_next_o    (stg_pc_next),
        .r_data_o     (stg_r_data)
    );

    mul_unit u_mul_unit (
        .clk            (clk),
        .reset_i        (reset_i),
        .mul_op_i       (ex_mul_op_i),
        .a_i            (ex_mul_a_i),
        .b_i            (ex_mul_b_i),
        .alu_m_result_o (stg_alu_m_result)
    );

    csr_file u_csr_file (
        .clk         (clk),
        .reset_i     (reset_i),
        .valid_i     (ex_valid_i),
        .csr_op_i    (ex_csr_op_i),
        .csr_addr_i  (ex_csr_addr_i),
        .csr_wdata_i (ex_csr_wdata_i),
        .csr_rdata_o (stg_csr_rdata)
    );

    writeback u_writeback (
        .rd_wrb_sel_i    (stg_rd_wrb_sel),
        .rd_addr_i       (stg_rd_addr),
        .rd_wr_req_i     (stg_rd_wr_req),
        .alu_result_i    (stg_alu_result),
        .pc_next_i       (stg_pc_next),
        .r_data_i        (stg_r_data),
        .alu_m_result_i  (stg_alu_m_result),
        .csr_rdata_i     (stg_csr_rdata),
        .wrb_rd_addr_o   (wrb_rd_addr_o),
        .wrb_rd_data_o   (wrb_rd_data_o),
        .wrb_rd_wr_req_o (wrb_rd_wr_req_o)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .reset_i    (reset_i),
        .wr_en_i    (wrb_rd_wr_req_o),
        .wr_addr_i  (wrb_rd_addr_o),
        .wr_data_i  (wrb_rd_data_o),
        .rs1_addr_i (id_rs1_addr_i),
        .rs2_addr_i (id_rs2_addr_i),
        .rs1_data_o (rf_rs1_data),
        .rs2_data_o (rf_rs2_data)
    );

    fwd_unit u_fwd_unit (
        .rs1_addr_i      (id_rs1_addr_i),
        .rs2_addr_i      (id_rs2_addr_i),
        .rf_rs1_data_i   (rf_rs1_data),
        .rf_rs2_data_i   (rf_rs2_data),
        .wrb_rd_addr_i   (wrb_rd_addr_o),
        .wrb_rd_data_i   (wrb_rd_data_o),
        .wrb_rd_wr_req_i (wrb_rd_wr_req_o),
        .rs1_data_o      (id_rs1_data_o),
        .rs2_data_o      (id_rs2_data_o)
    );

endmodule : pcore_backend

`default_nettype wire

// ==== rtl/fwd_unit.sv ====
`default_nettype none

`include "pcore_consts.svh"

module fwd_unit (
    // Decode source addresses and the register file's view of them
    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    input  logic [`XLEN-1:0]       rf_rs1_data_i,
    input  logic [`XLEN-1:0]       rf_rs2_data_i,

    // Value being written back this cycle
    input  logic [`REG_ADDR_W-1:0] wrb_rd_addr_i,
    input  logic [`XLEN-1:0]       wrb_rd_data_i,
    input  logic                   wrb_rd_wr_req_i,

    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o
);

    logic rs1_hit;
    logic rs2_hit;

    // No x0 check needed, the write request already excludes it
    assign rs1_hit = wrb_rd_wr_req_i && (rs1_addr_i == wrb_rd_addr_i);
    assign rs2_hit = wrb_rd_wr_req_i && (rs2_addr_i == wrb_rd_addr_i);

    assign rs1_data_o = rs1_hit ? wrb_rd_data_i : rf_rs1_data_i;
    assign rs2_data_o = rs2_hit ? wrb_rd_data_i : rf_rs2_data_i;

endmodule : fwd_unit

`default_nettype wire

// ==== rtl/reg_file.sv ====
`default_nettype none

`include "pcore_consts.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   reset_i,

    input  logic                   wr_en_i,
    input  logic [`REG_ADDR_W-1:0] wr_addr_i,
    input  logic [`XLEN-1:0]       wr_data_i,

    input  logic [`REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_i,
    output logic [`XLEN-1:0]       rs1_data_o,
    output logic [`XLEN-1:0]       rs2_data_o
);

    logic [`XLEN-1:0] regs [2**`REG_ADDR_W];

    // x0 is cleared here and never written afterwards
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    // The stage is expected to have filtered x0 writes away
    assert property (@(posedge clk) disable iff (reset_i) wr_en_i |-> (wr_addr_i != '0))
        else $error("reg_file: write to x0 reached the register file");

endmodule : reg_file

`default_nettype wire

// ==== rtl/writeback.sv ====
`default_nettype none

`include "pcore_consts.svh"

module writeback import pcore_pkg::*; (
    // Registered control and payload from the stage
    input  rd_wrb_sel_e            rd_wrb_sel_i,
    input  logic [`REG_ADDR_W-1:0] rd_addr_i,
    input  logic                   rd_wr_req_i,
    input  logic [`XLEN-1:0]       alu_result_i,
    input  logic [`XLEN-1:0]       pc_next_i,
    input  logic [`XLEN-1:0]       r_data_i,
    input  logic [`XLEN-1:0]       alu_m_result_i,
    input  logic [`XLEN-1:0]       csr_rdata_i,

    // Feedback to register file, forwarding and top
    output logic [`REG_ADDR_W-1:0] wrb_rd_addr_o,
    output logic [`XLEN-1:0]       wrb_rd_data_o,
    output logic                   wrb_rd_wr_req_o
);

    logic [`XLEN-1:0] rd_data;

    // Destination data mux
    always_comb begin
        case (rd_wrb_sel_i)
            RD_WRB_ALU    : rd_data = alu_result_i;
            RD_WRB_M_ALU  : rd_data = alu_m_result_i;
            RD_WRB_INC_PC : rd_data = pc_next_i;
            RD_WRB_DMEM   : rd_data = r_data_i;
            RD_WRB_CSR    : rd_data = csr_rdata_i;
            default       : rd_data = '0;
        endcase
    end

    assign wrb_rd_data_o   = rd_data;
    assign wrb_rd_addr_o   = rd_addr_i;
    assign wrb_rd_wr_req_o = rd_wr_req_i;

    // A write request raised in the stage must name a real source here
    always_comb begin
        if (rd_wr_req_i) begin
            assert final (rd_wrb_sel_i inside {RD_WRB_ALU, RD_WRB_M_ALU, RD_WRB_INC_PC,
                                               RD_WRB_DMEM, RD_WRB_CSR})
                else $error("writeback: write request with illegal select");
        end
    end

endmodule : writeback

`default_nettype wire

// ==== rtl/csr_file.sv ====
`default_nettype none

`include "pcore_consts.svh"

module csr_file import pcore_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,

    input  logic                   valid_i,
    input  csr_op_e                csr_op_i,
    input  logic [`CSR_ADDR_W-1:0] csr_addr_i,
    input  logic [`XLEN-1:0]       csr_wdata_i,

    output logic [`XLEN-1:0]       csr_rdata_o
);

    logic [`XLEN-1:0] mscratch;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] csr_old;
    logic [`XLEN-1:0] csr_new;
    logic             csr_wr;

    // Old value by address, unimplemented CSRs read zero
    always_comb begin
        case (csr_addr_i)
            `CSR_MSCRATCH : csr_old = mscratch;
            `CSR_MTVEC    : csr_old = mtvec;
            default       : csr_old = '0;
        endcase
    end

    // Read-modify-write result
    always_comb begin
        case (csr_op_i)
            CSR_RW  : csr_new = csr_wdata_i;
            CSR_RS  : csr_new = csr_old | csr_wdata_i;
            CSR_RC  : csr_new = csr_old & ~csr_wdata_i;
            default : csr_new = csr_old;
        endcase
    end

    assign csr_wr = valid_i && (csr_op_i != CSR_NONE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mscratch <= '0;
            mtvec    <= '0;
        end else if (csr_wr) begin
            // Writes to unknown addresses fall through and are dropped
            if (csr_addr_i == `CSR_MSCRATCH) begin
                mscratch <= csr_new;
            end
            if (csr_addr_i == `CSR_MTVEC) begin
                mtvec <= csr_new;
            end
        end
    end

    // Value before this instruction's write, lined up with writeback
    always_ff @(posedge clk) begin
        csr_rdata_o <= csr_old;
    end

    assert property (@(posedge clk) disable iff (reset_i)
        valid_i |-> (!$isunknown(csr_op_i) &&
                     csr_op_i inside {CSR_NONE, CSR_RW, CSR_RS, CSR_RC}))
        else $error("csr_file: unknown CSR op on a valid instruction");

endmodule : csr_file

`default_nettype wire

// ==== rtl/mul_unit.sv ====
`default_nettype none

`include "pcore_consts.svh"

module mul_unit import pcore_pkg::*; (
    input  logic             clk,
    input  logic             reset_i,

    input  mul_op_e          mul_op_i,
    input  logic [`XLEN-1:0] a_i,
    input  logic [`XLEN-1:0] b_i,

    output logic [`XLEN-1:0] alu_m_result_o
);

    logic                      a_signed;
    logic                      b_signed;
    logic signed [`XLEN:0]     a_ext;
    logic signed [`XLEN:0]     b_ext;
    logic signed [2*`XLEN-1:0] product;
    logic [`XLEN-1:0]          result_d;

    // MULH takes both operands signed, MULHSU only the first one
    assign a_signed = (mul_op_i == MUL_HSS) || (mul_op_i == MUL_HSU);
    assign b_signed = (mul_op_i == MUL_HSS);

    // One extra bit lets a single signed multiplier cover all forms
    assign a_ext = {a_signed & a_i[`XLEN-1], a_i};
    assign b_ext = {b_signed & b_i[`XLEN-1], b_i};

    assign product = a_ext * b_ext;

    // MUL wants the low word, the MULH variants the high word
    assign result_d = (mul_op_i == MUL_LO) ? product[`XLEN-1:0]
                                           : product[2*`XLEN-1:`XLEN];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            alu_m_result_o <= '0;
        end else begin
            alu_m_result_o <= result_d;
        end
    end

endmodule : mul_unit

`default_nettype wire

// ==== rtl/lsu_stage.sv ====
`default_nettype none

`include "pcore_consts.svh"

module lsu_stage import pcore_pkg::*; (
    input  logic                   clk,
    input  logic                   reset_i,

    input  logic                   valid_i,
    input  logic [`REG_ADDR_W-1:0] rd_addr_i,
    input  rd_wrb_sel_e            rd_wrb_sel_i,
    input  logic [`XLEN-1:0]       alu_result_i,
    input  logic [`XLEN-1:0]       pc_next_i,
    input  mem_op_e                mem_op_i,
    input  logic [`XLEN-1:0]       mem_addr_i,
    input  logic [`XLEN-1:0]       store_data_i,

    output logic [`REG_ADDR_W-1:0] rd_addr_o,
    output rd_wrb_sel_e            rd_wrb_sel_o,
    output logic                   rd_wr_req_o,
    output logic [`XLEN-1:0]       alu_result_o,
    output logic [`XLEN-1:0]       pc_next_o,
    output logic [`XLEN-1:0]       r_data_o
);

    logic [`XLEN-1:0]        dmem [`DMEM_WORDS];
    logic [`DMEM_ADDR_W-1:0] word_addr;
    logic                    rd_wr_req_d;

    assign word_addr = mem_addr_i[`DMEM_ADDR_W-1:0];

    // Only place where x0 is filtered out, downstream trusts this flag
    assign rd_wr_req_d = valid_i && (rd_wrb_sel_i != RD_WRB_NONE) && (rd_addr_i != '0);

    // Control part of the stage register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_wr_req_o  <= 1'b0;
            rd_wrb_sel_o <= RD_WRB_NONE;
        end else begin
            rd_wr_req_o  <= rd_wr_req_d;
            rd_wrb_sel_o <= rd_wrb_sel_i;
        end
    end

    // Payload carried along to writeback
    always_ff @(posedge clk) begin
        rd_addr_o    <= rd_addr_i;
        alu_result_o <= alu_result_i;
        pc_next_o    <= pc_next_i;
    end

    // Data memory, store and synchronous load
    always_ff @(posedge clk) begin
        if (valid_i && mem_op_i == MEM_STORE) begin
            dmem[word_addr] <= store_data_i;
        end
        if (valid_i && mem_op_i == MEM_LOAD) begin
            r_data_o <= dmem[word_addr];
        end
    end

    // Word address must fit the memory, no silent aliasing
    assert property (@(posedge clk) disable iff (reset_i)
        (valid_i && mem_op_i != MEM_NONE) |-> (mem_addr_i[`XLEN-1:`DMEM_ADDR_W] == '0))
        else $error("lsu_stage: data address beyond memory");

endmodule : lsu_stage

`default_nettype wire

// ==== common/pcore_pkg.sv ====
`default_nettype none

package pcore_pkg;

    // Source of the destination register value at writeback
    typedef enum logic [2:0] {
        RD_WRB_NONE   = 3'd0,
        RD_WRB_ALU    = 3'd1,
        RD_WRB_M_ALU  = 3'd2,
        RD_WRB_INC_PC = 3'd3,
        RD_WRB_DMEM   = 3'd4,
        RD_WRB_CSR    = 3'd5
    } rd_wrb_sel_e;

    // Data memory access
    typedef enum logic [1:0] {
        MEM_NONE  = 2'd0,
        MEM_LOAD  = 2'd1,
        MEM_STORE = 2'd2
    } mem_op_e;

    // M-extension multiply, low word or one of the three high-word forms
    typedef enum logic [1:0] {
        MUL_LO  = 2'd0,
        MUL_HSS = 2'd1,
        MUL_HUU = 2'd2,
        MUL_HSU = 2'd3
    } mul_op_e;

    // Zicsr read-modify-write flavours
    typedef enum logic [1:0] {
        CSR_NONE = 2'd0,
        CSR_RW   = 2'd1,
        CSR_RS   = 2'd2,
        CSR_RC   = 2'd3
    } csr_op_e;

endpackage : pcore_pkg

`default_nettype wire

// ==== common/pcore_consts.svh ====
`ifndef PCORE_CONSTS_SVH
`define PCORE_CONSTS_SVH

// Datapath word and register addressing
`define XLEN         32
`define REG_ADDR_W   5

// Data memory inside the load/store unit, word addressed
`define DMEM_WORDS   256
`define DMEM_ADDR_W  8

// CSR address space and the implemented machine CSRs
`define CSR_ADDR_W   12
`define CSR_MSCRATCH 12'h340
`define CSR_MTVEC    12'h305

`endif
